// ==== src/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// data word width
`define DC_WORD_BITS 32
// log2 words per line
`define DC_OFFSET_BITS 3
// log2 number of sets
`define DC_SET_BITS 3
`define DC_TAG_BITS 10
`define DC_WAYS 4
`define DC_WAY_BITS 2
// physical address bits actually used, the rest must be zero
`define DC_ADDR_BITS 16

// derived geometry
`define DC_SETS (1 << `DC_SET_BITS)
`define DC_LINE_WORDS (1 << `DC_OFFSET_BITS)
`define DC_LINE_BITS (`DC_WORD_BITS * `DC_LINE_WORDS)

// field positions inside a byte address
`define DC_OFF_LSB 2
`define DC_SET_LSB (`DC_OFF_LSB + `DC_OFFSET_BITS)
`define DC_TAG_LSB (`DC_SET_LSB + `DC_SET_BITS)

// worst case cycles the memory takes to answer a line request
`define DC_MEM_LATENCY 3

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

    // one data word
    typedef logic [`DC_WORD_BITS-1:0] word_t;
    // cpu or memory byte address
    typedef logic [31:0] addr_t;
    typedef logic [`DC_TAG_BITS-1:0] tag_t;
    typedef logic [`DC_SET_BITS-1:0] set_t;
    typedef logic [`DC_WAY_BITS-1:0] way_t;
    // word index inside a line
    typedef logic [`DC_OFFSET_BITS-1:0] offset_t;
    // whole line, word 0 sits in the top bits
    typedef logic [`DC_LINE_BITS-1:0] line_t;

    // store width, travels on the cpu port
    typedef enum logic [1:0] {
        STORE_BYTE = 2'd0,
        STORE_HALF = 2'd1,
        STORE_WORD = 2'd2
    } store_kind_e;

    // controller states
    typedef enum logic [1:0] {
        ST_READY     = 2'd0,
        ST_WRITEBACK = 2'd1,
        ST_REFILL    = 2'd2
    } ctrl_state_e;

endpackage

// ==== src/dcache_tag_array.sv ====
`include "dcache_defines.svh"

module dcache_tag_array (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::addr_t  addr_i,
    input  logic               fill_i,
    input  logic               store_i,
    output logic               hit_o,
    output dcache_pkg::way_t   hit_way_o,
    output dcache_pkg::way_t   victim_way_o,
    output logic               victim_dirty_o,
    output dcache_pkg::tag_t   victim_tag_o
);

    // per set state, one bit per way
    logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty_q [`DC_SETS];
    dcache_pkg::tag_t    tag_q   [`DC_SETS][`DC_WAYS];
    // round robin victim pointer per set
    dcache_pkg::way_t    fifo_q  [`DC_SETS];

    dcache_pkg::set_t    set_idx;
    dcache_pkg::tag_t    req_tag;
    logic [`DC_WAYS-1:0] hit_vec;

    // split the request address
    assign set_idx = addr_i[`DC_SET_LSB +: `DC_SET_BITS];
    assign req_tag = addr_i[`DC_TAG_LSB +: `DC_TAG_BITS];

    // compare all ways of the addressed set
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            hit_vec[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == req_tag);
            if (hit_vec[w])
                hit_way_o = dcache_pkg::way_t'(w);
        end
    end

    assign hit_o = |hit_vec;

    // victim is whatever the fifo pointer names
    assign victim_way_o   = fifo_q[set_idx];
    // only a valid and dirty line needs a writeback
    assign victim_dirty_o = valid_q[set_idx][victim_way_o] && dirty_q[set_idx][victim_way_o];
    assign victim_tag_o   = tag_q[set_idx][victim_way_o];

    // valid, dirty and fifo pointers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `DC_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                fifo_q[s]  <= '0;
            end
        end
        else
        begin
            if (fill_i)
            begin
                // fresh line from memory is clean
                valid_q[set_idx][victim_way_o] <= 1'b1;
                dirty_q[set_idx][victim_way_o] <= 1'b0;
                // 2-bit pointer wraps 3 -> 0 by itself
                fifo_q[set_idx] <= victim_way_o + 1'b1;
            end
            if (store_i)
                dirty_q[set_idx][hit_way_o] <= 1'b1;
        end
    end

    // tag written with the refill
    always_ff @(posedge clk)
    begin
        if (fill_i)
            tag_q[set_idx][victim_way_o] <= req_tag;
    end

    // fills only happen on a miss, so a tag never lands twice in one set
    a_single_hit: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(addr_i) |-> $onehot0(hit_vec)
    );

    // addresses touching the arrays stay inside the physical window
    a_addr_window: assert property (
        @(posedge clk) disable iff (rst)
        (fill_i || store_i) |-> (addr_i[31:`DC_ADDR_BITS] == '0)
    );

endmodule

// ==== src/dcache_data_array.sv ====
`include "dcache_defines.svh"

module dcache_data_array (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::addr_t        addr_i,
    input  dcache_pkg::word_t        wdata_i,
    input  dcache_pkg::store_kind_e  kind_i,
    input  dcache_pkg::way_t         hit_way_i,
    input  dcache_pkg::way_t         victim_way_i,
    input  logic                     fill_i,
    input  logic                     store_i,
    input  logic                     load_i,
    input  dcache_pkg::line_t        fill_line_i,
    output dcache_pkg::word_t        rdata_o,
    output dcache_pkg::line_t        victim_line_o
);

    // word storage, set x way x offset
    dcache_pkg::word_t   mem_q [`DC_SETS][`DC_WAYS][`DC_LINE_WORDS];

    dcache_pkg::set_t    set_idx;
    dcache_pkg::offset_t off_idx;
    logic [1:0]          byte_sel;

    assign set_idx  = addr_i[`DC_SET_LSB +: `DC_SET_BITS];
    assign off_idx  = addr_i[`DC_OFF_LSB +: `DC_OFFSET_BITS];
    assign byte_sel = addr_i[1:0];

    // byte 0 is the top lane of the word
    function automatic dcache_pkg::word_t merge_lanes(
        input dcache_pkg::word_t       old_w,
        input dcache_pkg::word_t       new_w,
        input dcache_pkg::store_kind_e kind,
        input logic [1:0]              sel
    );
        dcache_pkg::word_t res;
        res = old_w;
        case (kind)
            dcache_pkg::STORE_BYTE: res[(3 - sel) * 8 +: 8] = new_w[7:0];
            // bit 1 picks the half, bit 0 ignored
            dcache_pkg::STORE_HALF:
            begin
                if (sel[1])
                    res[15:0] = new_w[15:0];
                else
                    res[31:16] = new_w[15:0];
            end
            default: res = new_w;
        endcase
        return res;
    endfunction

    // store merge and line fill share the write port
    always_ff @(posedge clk)
    begin
        if (store_i)
            mem_q[set_idx][hit_way_i][off_idx] <=
                merge_lanes(mem_q[set_idx][hit_way_i][off_idx], wdata_i, kind_i, byte_sel);
        if (fill_i)
        begin
            for (int w = 0; w < `DC_LINE_WORDS; w++)
                mem_q[set_idx][victim_way_i][w] <=
                    fill_line_i[`DC_LINE_BITS - 1 - w * `DC_WORD_BITS -: `DC_WORD_BITS];
        end
    end

    // load data held until the next load
    always_ff @(posedge clk)
    begin
        if (load_i)
            rdata_o <= mem_q[set_idx][hit_way_i][off_idx];
    end

    // victim line packed for the memory port
    always_comb
    begin
        for (int w = 0; w < `DC_LINE_WORDS; w++)
            victim_line_o[`DC_LINE_BITS - 1 - w * `DC_WORD_BITS -: `DC_WORD_BITS] =
                mem_q[set_idx][victim_way_i][w];
    end

    // controller never fills and stores in the same cycle
    a_fill_store_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(fill_i && store_i)
    );

endmodule

// ==== src/dcache_ctrl.sv ====
`include "dcache_defines.svh"

module dcache_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_req_i,
    input  logic              wr_req_i,
    input  dcache_pkg::addr_t addr_i,
    input  logic              hit_i,
    input  logic              victim_dirty_i,
    input  dcache_pkg::tag_t  victim_tag_i,
    input  logic              mem_done_i,
    output logic              done_o,
    output logic              load_o,
    output logic              store_o,
    output logic              fill_o,
    output logic              mem_rd_req_o,
    output logic              mem_wr_req_o,
    output dcache_pkg::addr_t mem_addr_o
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;
    logic                    done_q;
    logic                    req;
    logic                    ready;
    dcache_pkg::set_t        set_idx;
    dcache_pkg::addr_t       wb_addr;
    dcache_pkg::addr_t       refill_addr;

    // the cycle after done is not a new request
    // the cpu drops its request only then
    assign req   = (rd_req_i || wr_req_i) && !done_q;
    assign ready = (state_q == dcache_pkg::ST_READY);

    // hit served by the array strobes in one edge
    assign load_o  = ready && req && hit_i && rd_req_i;
    assign store_o = ready && req && hit_i && wr_req_i;
    // refill lands with the memory strobe
    assign fill_o  = (state_q == dcache_pkg::ST_REFILL) && mem_done_i;

    // next state
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::ST_READY:
            begin
                // dirty victim goes out first
                if (req && !hit_i)
                    state_d = victim_dirty_i ? dcache_pkg::ST_WRITEBACK
                                             : dcache_pkg::ST_REFILL;
            end
            dcache_pkg::ST_WRITEBACK:
            begin
                if (mem_done_i)
                    state_d = dcache_pkg::ST_REFILL;
            end
            dcache_pkg::ST_REFILL:
            begin
                // line valid next cycle so the request then hits
                if (mem_done_i)
                    state_d = dcache_pkg::ST_READY;
            end
            default: state_d = dcache_pkg::ST_READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= dcache_pkg::ST_READY;
            done_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            // single cycle done strobe
            done_q  <= load_o || store_o;
        end
    end

    assign done_o = done_q;

    // moore memory requests
    assign mem_wr_req_o = (state_q == dcache_pkg::ST_WRITEBACK);
    assign mem_rd_req_o = (state_q == dcache_pkg::ST_REFILL);

    // victim line address rebuilt from its tag and the set
    assign set_idx = addr_i[`DC_SET_LSB +: `DC_SET_BITS];
    assign wb_addr = {{(32 - `DC_TAG_LSB - `DC_TAG_BITS){1'b0}}, victim_tag_i, set_idx,
                      {`DC_SET_LSB{1'b0}}};
    // request address with offset and byte bits cleared
    assign refill_addr = {addr_i[31:`DC_SET_LSB], {`DC_SET_LSB{1'b0}}};

    assign mem_addr_o = mem_wr_req_o ? wb_addr : refill_addr;

    // one memory transfer at a time
    a_mem_req_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_rd_req_o && mem_wr_req_o)
    );

    // cpu issues either a load or a store
    a_cpu_req_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(rd_req_i && wr_req_i)
    );

endmodule

// ==== src/dcache_top.sv ====
module dcache_top (
    input  logic                     clk,
    input  logic                     rst,
    // cpu side
    input  logic                     rd_req_i,
    input  logic                     wr_req_i,
    input  dcache_pkg::addr_t        addr_i,
    input  dcache_pkg::word_t        wdata_i,
    input  dcache_pkg::store_kind_e  kind_i,
    output logic                     done_o,
    output dcache_pkg::word_t        rdata_o,
    // memory side
    input  logic                     mem_done_i,
    input  dcache_pkg::line_t        mem_rdata_i,
    output logic                     mem_rd_req_o,
    output logic                     mem_wr_req_o,
    output dcache_pkg::addr_t        mem_addr_o,
    output dcache_pkg::line_t        mem_wdata_o
);

    // tag array results
    logic              hit;
    dcache_pkg::way_t  hit_way;
    dcache_pkg::way_t  victim_way;
    logic              victim_dirty;
    dcache_pkg::tag_t  victim_tag;

    // controller strobes
    logic              load;
    logic              store;
    logic              fill;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rd_req_i       (rd_req_i),
        .wr_req_i       (wr_req_i),
        .addr_i         (addr_i),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .mem_done_i     (mem_done_i),
        .done_o         (done_o),
        .load_o         (load),
        .store_o        (store),
        .fill_o         (fill),
        .mem_rd_req_o   (mem_rd_req_o),
        .mem_wr_req_o   (mem_wr_req_o),
        .mem_addr_o     (mem_addr_o)
    );

    dcache_tag_array u_tags (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (addr_i),
        .fill_i         (fill),
        .store_i        (store),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // victim line goes straight out as writeback data
    dcache_data_array u_data (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .kind_i         (kind_i),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .fill_i         (fill),
        .store_i        (store),
        .load_i         (load),
        .fill_line_i    (mem_rdata_i),
        .rdata_o        (rdata_o),
        .victim_line_o  (mem_wdata_o)
    );

endmodule

// ==== verif/dcache_mem_model.sv ====
`include "dcache_defines.svh"

module dcache_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_rd_req_i,
    input  logic              mem_wr_req_i,
    input  dcache_pkg::addr_t mem_addr_i,
    input  dcache_pkg::line_t mem_wdata_i,
    output logic              mem_done_o,
    output dcache_pkg::line_t mem_rdata_o,
    output dcache_pkg::addr_t last_wb_addr_o,
    output dcache_pkg::line_t last_wb_line_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 16-bit physical space, 32-byte lines
    localparam int LINES = 1 << (`DC_ADDR_BITS - `DC_SET_LSB);

    dcache_pkg::line_t lines_q   [LINES];
    logic              written_q [LINES];
    int                wait_cnt = 0;
    logic              done_q = 1'b0;
    dcache_pkg::line_t rdata_q = '0;
    dcache_pkg::addr_t wb_addr_q = '0;
    dcache_pkg::line_t wb_line_q = '0;
    logic [`DC_ADDR_BITS-`DC_SET_LSB-1:0] line_idx;

    assign line_idx       = mem_addr_i[`DC_ADDR_BITS-1:`DC_SET_LSB];
    assign mem_done_o     = done_q;
    assign mem_rdata_o    = rdata_q;
    assign last_wb_addr_o = wb_addr_q;
    assign last_wb_line_o = wb_line_q;

    // untouched memory: every word holds its own byte address xor a marker
    function automatic dcache_pkg::line_t pattern_line(input dcache_pkg::addr_t base);
        dcache_pkg::line_t l;
        for (int w = 0; w < `DC_LINE_WORDS; w++)
            l[`DC_LINE_BITS - 1 - 32 * w -: 32] = (base + 32'(4 * w)) ^ 32'hA5A5_0000;
        return l;
    endfunction

    // answers on the falling edge, like the rest of the stimulus
    always @(negedge clk)
    begin
        if (rst)
        begin
            done_q   <= 1'b0;
            wait_cnt <= 0;
            for (int i = 0; i < LINES; i++)
                written_q[i] <= 1'b0;
        end
        else if (done_q)
        begin
            // strobe lasts one cycle
            done_q   <= 1'b0;
            wait_cnt <= 0;
        end
        else if (mem_rd_req_i || mem_wr_req_i)
        begin
            if (wait_cnt == `DC_MEM_LATENCY - 1)
            begin
                done_q <= 1'b1;
                if (mem_wr_req_i)
                begin
                    lines_q[line_idx]   <= mem_wdata_i;
                    written_q[line_idx] <= 1'b1;
                    wb_addr_q           <= mem_addr_i;
                    wb_line_q           <= mem_wdata_i;
                end
                else if (written_q[line_idx])
                    rdata_q <= lines_q[line_idx];
                else
                    rdata_q <= pattern_line({mem_addr_i[31:`DC_SET_LSB], 5'b0});
            end
            else
                wait_cnt <= wait_cnt + 1;
        end
    end

endmodule

// ==== verif/dcache_tb.sv ====
`include "dcache_defines.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // 1 + 1 + 14 + 6 + 200 cpu operations
    localparam int NUM_OPS      = 222;
    // twice 20 cycles per operation
    localparam int CYCLE_LIMIT  = NUM_OPS * 20 * 2;
    localparam int SHADOW_WORDS = 1 << (`DC_ADDR_BITS - 2);

    logic                    clk;
    logic                    rst;
    logic                    rd_req;
    logic                    wr_req;
    dcache_pkg::addr_t       addr;
    dcache_pkg::word_t       wdata;
    dcache_pkg::store_kind_e kind;
    logic                    done;
    dcache_pkg::word_t       rdata;
    logic                    mem_rd_req;
    logic                    mem_wr_req;
    logic                    mem_done;
    dcache_pkg::addr_t       mem_addr;
    dcache_pkg::line_t       mem_wdata;
    dcache_pkg::line_t       mem_rdata;
    dcache_pkg::addr_t       last_wb_addr;
    dcache_pkg::line_t       last_wb_line;

    // expected memory image with one word per entry
    dcache_pkg::word_t       shadow [SHADOW_WORDS];
    int                      seed = 64969;
    int                      checks = 0;
    int                      errors = 0;
    int                      test_base = 0;
    int                      cycle_cnt = 0;
    int                      op_cycles;
    logic                    exp_load = 1'b0;
    dcache_pkg::word_t       exp_rdata = '0;
    // memory traffic seen during the last operation
    logic                    saw_rd;
    logic                    saw_wr;
    logic                    rd_after_wr;
    dcache_pkg::addr_t       rd_addr;
    dcache_pkg::addr_t       wr_addr;

    dcache_top uut (
        .clk          (clk),
        .rst          (rst),
        .rd_req_i     (rd_req),
        .wr_req_i     (wr_req),
        .addr_i       (addr),
        .wdata_i      (wdata),
        .kind_i       (kind),
        .done_o       (done),
        .rdata_o      (rdata),
        .mem_done_i   (mem_done),
        .mem_rdata_i  (mem_rdata),
        .mem_rd_req_o (mem_rd_req),
        .mem_wr_req_o (mem_wr_req),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata)
    );

    dcache_mem_model u_mem (
        .clk            (clk),
        .rst            (rst),
        .mem_rd_req_i   (mem_rd_req),
        .mem_wr_req_i   (mem_wr_req),
        .mem_addr_i     (mem_addr),
        .mem_wdata_i    (mem_wdata),
        .mem_done_o     (mem_done),
        .mem_rdata_o    (mem_rdata),
        .last_wb_addr_o (last_wb_addr),
        .last_wb_line_o (last_wb_line)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // lane rule on a byte view
    // byte 0 is the top of the word
    function automatic dcache_pkg::word_t ref_access(input logic is_store,
            input dcache_pkg::addr_t a, input dcache_pkg::word_t d,
            input dcache_pkg::store_kind_e k);
        logic [7:0] b [4];
        int         idx;
        idx = int'(a[`DC_ADDR_BITS-1:2]);
        for (int i = 0; i < 4; i++)
            b[i] = shadow[idx][31 - 8 * i -: 8];
        if (is_store)
        begin
            case (k)
                dcache_pkg::STORE_BYTE: b[a[1:0]] = d[7:0];
                dcache_pkg::STORE_HALF:
                begin
                    b[{a[1], 1'b0}] = d[15:8];
                    b[{a[1], 1'b1}] = d[7:0];
                end
                default:
                begin
                    for (int i = 0; i < 4; i++)
                        b[i] = d[31 - 8 * i -: 8];
                end
            endcase
            shadow[idx] = {b[0], b[1], b[2], b[3]};
        end
        return {b[0], b[1], b[2], b[3]};
    endfunction

    // expected contents of a whole line with word 0 on top
    function automatic dcache_pkg::line_t shadow_line(input dcache_pkg::addr_t base);
        dcache_pkg::line_t l;
        int                first;
        first = int'(base[`DC_ADDR_BITS-1:`DC_SET_LSB]) * `DC_LINE_WORDS;
        for (int w = 0; w < `DC_LINE_WORDS; w++)
            l[`DC_LINE_BITS - 1 - 32 * w -: 32] = shadow[first + w];
        return l;
    endfunction

    task automatic check_word(input string name, input dcache_pkg::word_t got,
            input dcache_pkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input dcache_pkg::line_t got,
            input dcache_pkg::line_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t got,
            input dcache_pkg::addr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        if (!cond)
        begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished, %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // one cpu access held until done
    // memory traffic recorded meanwhile
    task automatic run_op(input logic is_store, input dcache_pkg::addr_t a,
            input dcache_pkg::word_t d, input dcache_pkg::store_kind_e k);
        dcache_pkg::word_t expect_w;
        expect_w = ref_access(is_store, a, d, k);
        @(negedge clk);
        rd_req      = !is_store;
        wr_req      = is_store;
        addr        = a;
        wdata       = d;
        kind        = k;
        exp_load    = !is_store;
        exp_rdata   = expect_w;
        saw_rd      = 1'b0;
        saw_wr      = 1'b0;
        rd_after_wr = 1'b0;
        op_cycles   = 0;
        // wait for the done strobe
        do
        begin
            @(negedge clk);
            op_cycles++;
            if (mem_wr_req && !saw_wr)
            begin
                saw_wr  = 1'b1;
                wr_addr = mem_addr;
            end
            if (mem_rd_req && !saw_rd)
            begin
                saw_rd      = 1'b1;
                rd_addr     = mem_addr;
                rd_after_wr = saw_wr;
            end
        end
        while (!done);
        rd_req = 1'b0;
        wr_req = 1'b0;
        // return once the compare process has seen this done
        @(posedge clk);
    endtask

    // load results compared while done is high
    always @(negedge clk)
    begin
        if (!rst && done && exp_load)
            check_word("rdata_o", rdata, exp_rdata);
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: no finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        logic [31:0]             r;
        dcache_pkg::addr_t       a;
        dcache_pkg::store_kind_e k;
        rst    = 1'b1;
        rd_req = 1'b0;
        wr_req = 1'b0;
        addr   = '0;
        wdata  = '0;
        kind   = dcache_pkg::STORE_WORD;
        for (int i = 0; i < SHADOW_WORDS; i++)
            shadow[i] = 32'(4 * i) ^ 32'hA5A5_0000;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // word offset 2 of set 2
        run_op(1'b0, 32'h0000_1A48, '0, dcache_pkg::STORE_WORD);
        check_true(saw_rd, "cold load finished without a memory refill request");
        check_addr("mem_addr_o", rd_addr, 32'h0000_1A40);
        finish_test("cold_read_miss");

        run_op(1'b0, 32'h0000_1A48, '0, dcache_pkg::STORE_WORD);
        check_true(!saw_rd && !saw_wr, "read hit went out to memory");
        check_true(op_cycles == 1, "read hit took more than one cycle");
        finish_test("read_hit");

        for (int i = 0; i < 4; i++)
        begin
            run_op(1'b1, 32'h0000_1A48 + 32'(i), {24'hABCDEF, 8'(8'h11 * (i + 1))},
                dcache_pkg::STORE_BYTE);
            run_op(1'b0, 32'h0000_1A48, '0, dcache_pkg::STORE_WORD);
        end
        for (int i = 0; i < 4; i += 2)
        begin
            run_op(1'b1, 32'h0000_1A48 + 32'(i), {16'h5555, 16'h1234 + 16'(i)},
                dcache_pkg::STORE_HALF);
            run_op(1'b0, 32'h0000_1A48, '0, dcache_pkg::STORE_WORD);
        end
        run_op(1'b1, 32'h0000_1A48, 32'h0BAD_F00D, dcache_pkg::STORE_WORD);
        run_op(1'b0, 32'h0000_1A48, '0, dcache_pkg::STORE_WORD);
        finish_test("store_lanes");

        // tags 1 to 5 at offset 4 of set 6
        for (int t = 1; t <= 5; t++)
        begin
            a = (32'(t) << 8) | 32'h0000_00D0;
            run_op(1'b1, a, 32'hC0DE_0000 | 32'(t), dcache_pkg::STORE_WORD);
            if (t < 5)
                check_true(!saw_wr, "store into a free way wrote a line back");
        end
        check_true(saw_wr && rd_after_wr, "fifth miss did not write back before the refill");
        check_addr("mem_addr_o", wr_addr, 32'h0000_01C0);
        check_addr("last_wb_addr", last_wb_addr, 32'h0000_01C0);
        check_line("mem_wdata_o", last_wb_line, shadow_line(32'h0000_01C0));
        // first tag comes back from memory
        // second tag goes out
        run_op(1'b0, 32'h0000_01D0, '0, dcache_pkg::STORE_WORD);
        check_true(saw_wr, "reload of the first tag evicted no dirty line");
        check_addr("mem_addr_o", wr_addr, 32'h0000_02C0);
        finish_test("fifo_eviction");

        // 8 tags over sets 0 to 3
        for (int n = 0; n < 200; n++)
        begin
            r = $random(seed);
            a = {16'h0, 5'h0, r[2:0], 1'b0, r[4:3], r[7:5], r[9:8]};
            k = dcache_pkg::store_kind_e'((r[14:13] == 2'd3) ? 2'd2 : r[14:13]);
            if (r[12])
                run_op(1'b1, a, $random(seed), k);
            else
                run_op(1'b0, a & 32'hFFFF_FFFC, '0, dcache_pkg::STORE_WORD);
        end
        finish_test("random_traffic");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== dcache.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the data cache testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache.f --top-module dcache_tb -o dcache_sim \
    && { sim_out=$(./obj_dir/dcache_sim); echo "$sim_out"; } \
    && grep -q "TEST OK" <<< "$sim_out" \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed"; exit 1; }
